/* common/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    // datapath width for operands, addresses and pc
    parameter int DATA_W = 32;

    // architectural register number
    parameter int REG_W = 5;

    // top level overrides this through its own parameter
    parameter int ROB_DEPTH_DEF = 8;

    // dispatched operation
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_BEQ = 3'd2,
        OP_BNE = 3'd3,
        OP_SW  = 3'd4
    } op_t;

endpackage

`default_nettype wire

/* rob/rob.sv */
`timescale 1ns/1ns
`default_nettype none

module rob #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          alloc_en,
    input  ooo_pkg::op_t                  alloc_op,
    input  logic [ooo_pkg::REG_W-1:0]     alloc_rd,
    input  logic                          alloc_pred,
    input  logic                          ex_done,
    input  logic [$clog2(ROB_DEPTH)-1:0]  ex_tag,
    input  logic [ooo_pkg::DATA_W-1:0]    ex_result,
    input  logic                          ex_taken,
    input  logic [ooo_pkg::DATA_W-1:0]    ex_target,
    input  logic                          st_ready,
    input  logic [$clog2(ROB_DEPTH)-1:0]  st_tag,
    input  logic                          st_drained,
    output logic [$clog2(ROB_DEPTH)-1:0]  alloc_tag,
    output logic                          full,
    output logic                          st_release,
    output logic [$clog2(ROB_DEPTH)-1:0]  release_tag,
    output logic                          commit_en,
    output logic [ooo_pkg::REG_W-1:0]     commit_rd,
    output logic [ooo_pkg::DATA_W-1:0]    commit_data,
    output logic [$clog2(ROB_DEPTH)-1:0]  commit_tag,
    output logic                          redirect_en,
    output logic [ooo_pkg::DATA_W-1:0]    redirect_pc
);

    import ooo_pkg::*;

    localparam int TAG_W = $clog2(ROB_DEPTH);

    typedef enum logic [1:0] {
        K_REG,
        K_BRANCH,
        K_STORE
    } kind_t;

    // entry storage
    kind_t                kind_q   [ROB_DEPTH];
    logic [REG_W-1:0]     rd_q     [ROB_DEPTH];
    logic [DATA_W-1:0]    data_q   [ROB_DEPTH];
    logic                 pred_q   [ROB_DEPTH];
    logic                 actual_q [ROB_DEPTH];
    logic [DATA_W-1:0]    target_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;

    logic [TAG_W-1:0] head;
    logic [TAG_W-1:0] tail;
    logic [TAG_W:0]   count;
    logic             rel_pending;

    kind_t alloc_kind;
    logic  head_ready;
    logic  mispredict;
    logic  pop;
    logic  flush_now;

    function automatic logic [TAG_W-1:0] next_ptr(input logic [TAG_W-1:0] p);
        logic [TAG_W-1:0] n;
        if (p == TAG_W'(ROB_DEPTH - 1)) begin
            n = '0;
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    assign alloc_tag  = tail;
    assign full       = (count == (TAG_W + 1)'(ROB_DEPTH));
    assign head_ready = (count != '0) && done_q[head];
    assign mispredict = (pred_q[head] != actual_q[head]);

    always_comb begin
        case (alloc_op)
            OP_SW:          alloc_kind = K_STORE;
            OP_BEQ, OP_BNE: alloc_kind = K_BRANCH;
            default:        alloc_kind = K_REG;
        endcase
    end

    // retirement decision for the head entry
    always_comb begin
        pop       = 1'b0;
        flush_now = 1'b0;
        if (head_ready) begin
            case (kind_q[head])
                K_REG: begin
                    pop = 1'b1;
                end
                K_BRANCH: begin
                    pop       = 1'b1;
                    flush_now = mispredict;
                end
                default: begin
                    // store leaves only once memory has taken it
                    pop = rel_pending && st_drained;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            done_q      <= '0;
            rel_pending <= 1'b0;
            commit_en   <= 1'b0;
            redirect_en <= 1'b0;
            st_release  <= 1'b0;
        end else begin
            commit_en   <= head_ready && (kind_q[head] == K_REG);
            redirect_en <= flush_now;
            st_release  <= 1'b0;

            if (head_ready && kind_q[head] == K_STORE && !rel_pending) begin
                st_release  <= 1'b1;
                rel_pending <= 1'b1;
            end
            if (pop && kind_q[head] == K_STORE) begin
                rel_pending <= 1'b0;
            end

            if (ex_done) begin
                done_q[ex_tag] <= 1'b1;
            end
            if (st_ready) begin
                done_q[st_tag] <= 1'b1;
            end

            if (flush_now) begin
                // younger entries are dropped, a same-cycle alloc included
                head   <= '0;
                tail   <= '0;
                count  <= '0;
                done_q <= '0;
            end else begin
                if (alloc_en) begin
                    done_q[tail] <= 1'b0;
                    tail         <= next_ptr(tail);
                end
                if (pop) begin
                    head <= next_ptr(head);
                end
                count <= count + (TAG_W + 1)'(alloc_en) - (TAG_W + 1)'(pop);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            kind_q[tail] <= alloc_kind;
            rd_q[tail]   <= alloc_rd;
            pred_q[tail] <= alloc_pred;
        end
        if (ex_done) begin
            data_q[ex_tag]   <= ex_result;
            actual_q[ex_tag] <= ex_taken;
            target_q[ex_tag] <= ex_target;
        end
        if (head_ready) begin
            commit_rd   <= rd_q[head];
            commit_data <= data_q[head];
            commit_tag  <= head;
            redirect_pc <= target_q[head];
            release_tag <= head;
        end
    end

endmodule

`default_nettype wire

/* hw/int_branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module int_branch_unit #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic [$clog2(ROB_DEPTH)-1:0] tag,
    input  ooo_pkg::op_t                 op,
    input  logic [ooo_pkg::DATA_W-1:0]   a,
    input  logic [ooo_pkg::DATA_W-1:0]   b,
    input  logic [ooo_pkg::DATA_W-1:0]   pc,
    input  logic [ooo_pkg::DATA_W-1:0]   imm,
    input  logic                         flush,
    output logic                         ex_done,
    output logic [$clog2(ROB_DEPTH)-1:0] ex_tag,
    output logic [ooo_pkg::DATA_W-1:0]   ex_result,
    output logic                         ex_taken,
    output logic [ooo_pkg::DATA_W-1:0]   ex_target
);

    import ooo_pkg::*;

    logic              pending;
    logic [DATA_W-1:0] result_d;
    logic              taken_d;

    always_comb begin
        result_d = '0;
        taken_d  = 1'b0;
        case (op)
            OP_ADD:  result_d = a + b;
            OP_SUB:  result_d = a - b;
            OP_BEQ:  taken_d = (a == b);
            OP_BNE:  taken_d = (a != b);
            default: result_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= start && !flush;
        end
    end

    // resolved next pc for a redirect
    always_ff @(posedge clk) begin
        if (start) begin
            ex_tag    <= tag;
            ex_result <= result_d;
            ex_taken  <= taken_d;
            ex_target <= taken_d ? (pc + imm) : (pc + DATA_W'(4));
        end
    end

    // result still in flight during a redirect is cancelled
    assign ex_done = pending && !flush;

endmodule

`default_nettype wire

/* hw/store_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module store_buffer #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wr_en,
    input  logic [$clog2(ROB_DEPTH)-1:0] wr_tag,
    input  logic [ooo_pkg::DATA_W-1:0]   a,
    input  logic [ooo_pkg::DATA_W-1:0]   b,
    input  logic [ooo_pkg::DATA_W-1:0]   imm,
    input  logic                         st_release,
    input  logic [$clog2(ROB_DEPTH)-1:0] release_tag,
    input  logic                         flush,
    input  logic                         mem_ack,
    output logic                         st_ready,
    output logic [$clog2(ROB_DEPTH)-1:0] st_tag,
    output logic                         st_drained,
    output logic                         mem_req,
    output logic [ooo_pkg::DATA_W-1:0]   mem_addr,
    output logic [ooo_pkg::DATA_W-1:0]   mem_data
);

    import ooo_pkg::*;

    localparam int TAG_W = $clog2(ROB_DEPTH);

    typedef enum logic [1:0] {
        M_IDLE,
        M_REQ,
        M_WAIT_LOW
    } mem_state_t;

    logic [DATA_W-1:0]    addr_q [ROB_DEPTH];
    logic [DATA_W-1:0]    data_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] valid_q;
    logic [TAG_W-1:0]     cur_tag;
    logic                 ready_q;
    mem_state_t           state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= M_IDLE;
            mem_req    <= 1'b0;
            st_drained <= 1'b0;
            ready_q    <= 1'b0;
            valid_q    <= '0;
        end else begin
            st_drained <= 1'b0;
            ready_q    <= wr_en && !flush;
            if (wr_en) begin
                valid_q[wr_tag] <= 1'b1;
            end

            // four-phase with memory for the released entry
            case (state)
                M_IDLE: begin
                    if (st_release && valid_q[release_tag]) begin
                        mem_req <= 1'b1;
                        state   <= M_REQ;
                    end
                end
                M_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= M_WAIT_LOW;
                    end
                end
                default: begin
                    if (!mem_ack) begin
                        st_drained       <= 1'b1;
                        valid_q[cur_tag] <= 1'b0;
                        state            <= M_IDLE;
                    end
                end
            endcase

            if (flush) begin
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    if (state == M_IDLE || cur_tag != TAG_W'(i)) begin
                        valid_q[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            addr_q[wr_tag] <= a + imm;
            data_q[wr_tag] <= b;
            st_tag         <= wr_tag;
        end
        if (state == M_IDLE && st_release) begin
            cur_tag  <= release_tag;
            mem_addr <= addr_q[release_tag];
            mem_data <= data_q[release_tag];
        end
    end

    assign st_ready = ready_q && !flush;

endmodule

`default_nettype wire

/* hw/ooo_backend_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ooo_backend_top #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         disp_req,
    input  ooo_pkg::op_t                 disp_op,
    input  logic [ooo_pkg::REG_W-1:0]    disp_rd,
    input  logic [ooo_pkg::DATA_W-1:0]   disp_a,
    input  logic [ooo_pkg::DATA_W-1:0]   disp_b,
    input  logic [ooo_pkg::DATA_W-1:0]   disp_pc,
    input  logic [ooo_pkg::DATA_W-1:0]   disp_imm,
    input  logic                         disp_pred,
    input  logic                         mem_ack,
    output logic                         disp_ack,
    output logic                         commit_en,
    output logic [ooo_pkg::REG_W-1:0]    commit_rd,
    output logic [ooo_pkg::DATA_W-1:0]   commit_data,
    output logic [$clog2(ROB_DEPTH)-1:0] commit_tag,
    output logic                         redirect_en,
    output logic [ooo_pkg::DATA_W-1:0]   redirect_pc,
    output logic                         mem_req,
    output logic [ooo_pkg::DATA_W-1:0]   mem_addr,
    output logic [ooo_pkg::DATA_W-1:0]   mem_data
);

    import ooo_pkg::*;

    localparam int TAG_W = $clog2(ROB_DEPTH);

    // acked holds ack high until the request falls
    typedef enum logic {
        D_IDLE,
        D_ACKED
    } disp_state_t;

    disp_state_t       dstate;
    logic              alloc_en;
    logic              is_store;
    logic              full;
    logic [TAG_W-1:0]  alloc_tag;
    logic              ex_done;
    logic [TAG_W-1:0]  ex_tag;
    logic [DATA_W-1:0] ex_result;
    logic              ex_taken;
    logic [DATA_W-1:0] ex_target;
    logic              st_ready;
    logic [TAG_W-1:0]  st_tag;
    logic              st_drained;
    logic              st_release;
    logic [TAG_W-1:0]  release_tag;

    assign alloc_en = (dstate == D_IDLE) && disp_req && !full && !redirect_en;
    assign is_store = (disp_op == OP_SW);
    assign disp_ack = (dstate == D_ACKED);

    always_ff @(posedge clk) begin
        if (rst) begin
            dstate <= D_IDLE;
        end else begin
            case (dstate)
                D_IDLE:  if (alloc_en) dstate <= D_ACKED;
                default: if (!disp_req) dstate <= D_IDLE;
            endcase
        end
    end

    rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk(clk), .rst(rst),
        .alloc_en(alloc_en), .alloc_op(disp_op), .alloc_rd(disp_rd),
        .alloc_pred(disp_pred),
        .ex_done(ex_done), .ex_tag(ex_tag), .ex_result(ex_result),
        .ex_taken(ex_taken), .ex_target(ex_target),
        .st_ready(st_ready), .st_tag(st_tag), .st_drained(st_drained),
        .alloc_tag(alloc_tag), .full(full),
        .st_release(st_release), .release_tag(release_tag),
        .commit_en(commit_en), .commit_rd(commit_rd),
        .commit_data(commit_data), .commit_tag(commit_tag),
        .redirect_en(redirect_en), .redirect_pc(redirect_pc)
    );

    // add, sub and branches go to the execution unit
    int_branch_unit #(.ROB_DEPTH(ROB_DEPTH)) u_exu (
        .clk(clk), .rst(rst),
        .start(alloc_en && !is_store), .tag(alloc_tag), .op(disp_op),
        .a(disp_a), .b(disp_b), .pc(disp_pc), .imm(disp_imm),
        .flush(redirect_en),
        .ex_done(ex_done), .ex_tag(ex_tag), .ex_result(ex_result),
        .ex_taken(ex_taken), .ex_target(ex_target)
    );

    store_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_stb (
        .clk(clk), .rst(rst),
        .wr_en(alloc_en && is_store), .wr_tag(alloc_tag),
        .a(disp_a), .b(disp_b), .imm(disp_imm),
        .st_release(st_release), .release_tag(release_tag),
        .flush(redirect_en), .mem_ack(mem_ack),
        .st_ready(st_ready), .st_tag(st_tag), .st_drained(st_drained),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_data(mem_data)
    );

endmodule

`default_nettype wire

/* verification/ooo_backend_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module ooo_backend_sva (
    input logic                       clk,
    input logic                       rst,
    input logic                       disp_req,
    input logic                       disp_ack,
    input logic                       mem_req,
    input logic                       mem_ack,
    input logic [ooo_pkg::DATA_W-1:0] mem_addr,
    input logic [ooo_pkg::DATA_W-1:0] mem_data,
    input logic                       commit_en,
    input logic                       redirect_en
);

    // count of failed properties
    int violations = 0;

    ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        $rose(disp_ack) |-> disp_req && $past(disp_req))
    else begin
        violations++;
        $error("disp_ack rose without a pending disp_req");
    end

    // req falls only while acked, ack falls only once req is low
    disp_four_phase: assert property (@(posedge clk) disable iff (rst)
        ($fell(disp_req) |-> disp_ack) and ($fell(disp_ack) |-> !disp_req)
        and ($rose(disp_req) |-> !disp_ack))
    else begin
        violations++;
        $error("dispatch handshake left four-phase order");
    end

    mem_payload_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_data))
    else begin
        violations++;
        $error("mem_addr or mem_data changed during mem_req");
    end

    mem_req_drops_on_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(mem_req) |-> mem_ack)
    else begin
        violations++;
        $error("mem_req dropped before mem_ack");
    end

    commit_redirect_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(commit_en && redirect_en))
    else begin
        violations++;
        $error("commit_en and redirect_en high in the same cycle");
    end

endmodule

bind ooo_backend_top ooo_backend_sva u_sva (
    .clk(clk), .rst(rst), .disp_req(disp_req), .disp_ack(disp_ack),
    .mem_req(mem_req), .mem_ack(mem_ack), .mem_addr(mem_addr), .mem_data(mem_data),
    .commit_en(commit_en), .redirect_en(redirect_en)
);

`default_nettype wire

/* verification/tb_ooo_backend.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_ooo_backend;

    import ooo_pkg::*;

    localparam int ROB_DEPTH  = 8;
    localparam int TAG_W      = $clog2(ROB_DEPTH);
    localparam int MAX_CYCLES = 3000;

    typedef struct packed {
        op_t               op;
        logic [REG_W-1:0]  rd;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] imm;
        logic              pred;
        logic [TAG_W-1:0]  tag;
    } instr_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              disp_req;
    op_t               disp_op;
    logic [REG_W-1:0]  disp_rd;
    logic [DATA_W-1:0] disp_a;
    logic [DATA_W-1:0] disp_b;
    logic [DATA_W-1:0] disp_pc;
    logic [DATA_W-1:0] disp_imm;
    logic              disp_pred;
    logic              mem_ack;
    logic              disp_ack;
    logic              commit_en;
    logic [REG_W-1:0]  commit_rd;
    logic [DATA_W-1:0] commit_data;
    logic [TAG_W-1:0]  commit_tag;
    logic              redirect_en;
    logic [DATA_W-1:0] redirect_pc;
    logic              mem_req;
    logic [DATA_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_data;

    integer            seed      = 32'h86cb;
    integer            mem_seed  = 32'h86cb;
    int                cycles    = 0;
    string             test_name = "reset";
    instr_t            model[$];
    logic [TAG_W-1:0]  next_tag  = '0;
    logic              mem_hold  = 1'b0;
    logic              ack_prev  = 1'b0;
    logic              mreq_prev = 1'b0;
    logic [DATA_W-1:0] pc_next   = 32'h0000_1000;

    ooo_backend_top #(.ROB_DEPTH(ROB_DEPTH)) uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic report_mismatch(input string what, input logic [DATA_W-1:0] expected,
                                   input logic [DATA_W-1:0] actual);
        $display("MISMATCH %s %s: expected %h actual %h", test_name, what, expected, actual);
        $display("TEST FAIL");
        $fatal(1, "value check failed");
    endtask

    task automatic report_error(input string what);
        $display("ERROR in %s: %s", test_name, what);
        $display("TEST FAIL");
        $fatal(1, "behavior check failed");
    endtask

    function automatic logic branch_taken(input instr_t i);
        if (i.op == OP_BEQ) begin
            return i.a == i.b;
        end
        return i.a != i.b;
    endfunction

    // correctly predicted branches leave no trace on the outputs
    function automatic logic retires_silently(input instr_t i);
        return (i.op == OP_BEQ || i.op == OP_BNE) && (branch_taken(i) == i.pred);
    endfunction

    function automatic int visible_count();
        int n = 0;
        foreach (model[k]) begin
            if (!retires_silently(model[k])) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic skip_silent_branches();
        while (model.size() != 0 && retires_silently(model[0])) begin
            void'(model.pop_front());
        end
    endtask

    // reference model fed in program order by the dispatch handshake
    always @(posedge clk) begin
        instr_t entry;
        instr_t oldest;
        if (!rst) begin
            assert (uut.u_sva.violations == 0)
                else report_error("a handshake or commit property failed");
            if (disp_ack && !ack_prev) begin
                entry = '{disp_op, disp_rd, disp_a, disp_b, disp_pc, disp_imm,
                          disp_pred, next_tag};
                next_tag = next_tag + 1'b1;
                model.push_back(entry);
            end
            if (commit_en) begin
                skip_silent_branches();
                assert (model.size() != 0)
                    else report_error("commit with no instruction outstanding");
                oldest = model.pop_front();
                assert (oldest.op == OP_ADD || oldest.op == OP_SUB)
                    else report_error("commit while the oldest instruction is not add or sub");
                assert (!mem_req && !mem_ack)
                    else report_error("commit while a store is still draining");
                assert (commit_rd == oldest.rd)
                    else report_mismatch("commit_rd", oldest.rd, commit_rd);
                assert (commit_tag == oldest.tag)
                    else report_mismatch("commit_tag", oldest.tag, commit_tag);
                assert (commit_data == ((oldest.op == OP_SUB) ? oldest.a - oldest.b
                                                              : oldest.a + oldest.b))
                    else report_mismatch("commit_data", (oldest.op == OP_SUB) ?
                        oldest.a - oldest.b : oldest.a + oldest.b, commit_data);
            end
            if (mem_req && !mreq_prev) begin
                skip_silent_branches();
                assert (model.size() != 0)
                    else report_error("memory write with no instruction outstanding");
                oldest = model.pop_front();
                assert (oldest.op == OP_SW)
                    else report_error("memory write while the oldest instruction is no store");
                assert (mem_addr == oldest.a + oldest.imm)
                    else report_mismatch("mem_addr", oldest.a + oldest.imm, mem_addr);
                assert (mem_data == oldest.b)
                    else report_mismatch("mem_data", oldest.b, mem_data);
            end
            if (redirect_en) begin
                skip_silent_branches();
                assert (model.size() != 0)
                    else report_error("redirect with no instruction outstanding");
                oldest = model.pop_front();
                assert (oldest.op == OP_BEQ || oldest.op == OP_BNE)
                    else report_error("redirect while the oldest instruction is no branch");
                assert (redirect_pc == (branch_taken(oldest) ? oldest.pc + oldest.imm
                                                             : oldest.pc + 32'd4))
                    else report_mismatch("redirect_pc", branch_taken(oldest) ?
                        oldest.pc + oldest.imm : oldest.pc + 32'd4, redirect_pc);
                // everything younger is gone and the ROB restarts at slot 0
                model.delete();
                next_tag = '0;
            end
        end
        ack_prev  = disp_ack;
        mreq_prev = mem_req;
    end

    initial begin : mem_responder
        int delay;
        forever begin
            @(posedge clk);
            if (!rst && mem_req && !mem_ack && !mem_hold) begin
                delay = $unsigned($random(mem_seed)) % 8;
                repeat (delay) @(posedge clk);
                mem_ack <= 1'b1;
                do begin
                    @(posedge clk);
                end while (mem_req);
                mem_ack <= 1'b0;
            end
        end
    end

    task automatic raise_request(input op_t op, input logic [DATA_W-1:0] a,
                                 input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] imm,
                                 input logic pred);
        disp_req  <= 1'b1;
        disp_op   <= op;
        disp_rd   <= REG_W'($random(seed));
        disp_a    <= a;
        disp_b    <= b;
        disp_pc   <= pc_next;
        disp_imm  <= imm;
        disp_pred <= pred;
        pc_next = pc_next + 32'd4;
    endtask

    task automatic complete_handshake();
        do begin
            @(posedge clk);
        end while (!disp_ack);
        disp_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (disp_ack);
    endtask

    task automatic send(input op_t op, input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                        input logic [DATA_W-1:0] imm, input logic pred);
        raise_request(op, a, b, imm, pred);
        complete_handshake();
        repeat ($unsigned($random(seed)) % 3) @(posedge clk);
    endtask

    task automatic send_alu();
        send(($random(seed) & 1) ? OP_SUB : OP_ADD, $random(seed), $random(seed), '0, 1'b0);
    endtask

    task automatic send_store();
        send(OP_SW, $random(seed), $random(seed), $random(seed) & 32'h0000_0ffc, 1'b0);
    endtask

    task automatic send_branch(input logic mispredict);
        op_t               op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic              taken;
        op = ($random(seed) & 1) ? OP_BNE : OP_BEQ;
        a = $random(seed);
        b = ($random(seed) & 1) ? a : $random(seed);
        taken = (op == OP_BEQ) ? (a == b) : (a != b);
        send(op, a, b, $random(seed) & 32'h0000_0ffc, taken ^ mispredict);
    endtask

    task automatic wait_drained();
        while (visible_count() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    initial begin
        rst       = 1'b1;
        disp_req  = 1'b0;
        disp_op   = OP_ADD;
        disp_rd   = '0;
        disp_a    = '0;
        disp_b    = '0;
        disp_pc   = '0;
        disp_imm  = '0;
        disp_pred = 1'b0;
        mem_ack   = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!disp_ack && !commit_en && !redirect_en && !mem_req)
            else report_error("control outputs not low after reset");

        test_name = "alu_in_order";
        repeat (16) send_alu();
        wait_drained();

        test_name = "store_blocks_younger";
        repeat (2) begin
            mem_hold <= 1'b1;
            send_store();
            repeat (3) send_alu();
            repeat (10) @(posedge clk);
            mem_hold <= 1'b0;
            wait_drained();
        end

        test_name = "store_stream";
        repeat (12) begin
            if ($random(seed) & 1) begin
                send_store();
            end else begin
                send_alu();
            end
        end
        wait_drained();

        test_name = "branch_redirect";
        repeat (8) begin
            send_branch($random(seed) & 1);
            send_alu();
        end
        wait_drained();
        // shadow add and store wait behind a branch stuck behind a held store
        mem_hold <= 1'b1;
        send_store();
        send_branch(1'b1);
        send_alu();
        send_store();
        mem_hold <= 1'b0;
        wait_drained();

        test_name = "back_pressure";
        mem_hold <= 1'b1;
        send_store();
        repeat (7) send_alu();
        raise_request(OP_ADD, $random(seed), $random(seed), '0, 1'b0);
        repeat (20) begin
            @(posedge clk);
            assert (!disp_ack)
                else report_error("ninth dispatch acknowledged while the ROB is full");
        end
        mem_hold <= 1'b0;
        complete_handshake();
        wait_drained();

        if (uut.u_sva.violations == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "concurrent property failures");
        end
    end

endmodule

`default_nettype wire

/* list.f */
common/ooo_pkg.sv
rob/rob.sv
hw/int_branch_unit.sv
hw/store_buffer.sv
hw/ooo_backend_top.sv
verification/ooo_backend_sva.sv
verification/tb_ooo_backend.sv
